//--- src/imap_match_pkg.sv
`default_nettype none

package imap_match_pkg;

  // Widest stream id carried on the control bus
  localparam int STREAM_ID_WIDTH_MAX = 6;

  // LOGIN automaton states, one per matched prefix length
  typedef enum logic [2:0] {
    S_IDLE  = 3'd0,
    S_L     = 3'd1,
    S_LO    = 3'd2,
    S_LOG   = 3'd3,
    S_LOGI  = 3'd4,
    S_LOGIN = 3'd5
  } dfa_state_e;

  // One input character with its strobe
  typedef struct packed {
    logic       char_vld;
    logic [7:0] char_val;
  } char_beat_t;

  // Per-packet control levels and strobes
  typedef struct packed {
    logic                           load_state;
    logic                           new_stream;
    logic                           enable;
    logic                           eop;
    logic [STREAM_ID_WIDTH_MAX-1:0] stream_id;
  } stream_ctl_t;

  // State overwrite from context restore into the automaton
  typedef struct packed {
    logic       restore_vld;
    dfa_state_e restore_state;
  } dfa_restore_t;

  // Registered automaton outputs
  typedef struct packed {
    logic       accept;
    dfa_state_e state;
  } dfa_result_t;

endpackage

`default_nettype wire

//--- src/stream_context.sv
`default_nettype none

module stream_context #(
  parameter int STREAM_ID_WIDTH = 6
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  imap_match_pkg::stream_ctl_t  ctl_in,
  input  imap_match_pkg::dfa_result_t  dfa_out,
  output imap_match_pkg::dfa_restore_t restore
);

  import imap_match_pkg::*;

  // One context entry per stream
  localparam int CTX_DEPTH = 2 ** STREAM_ID_WIDTH;

  // Saved automaton state per stream, contents undefined until first save
  dfa_state_e ctx_mem [CTX_DEPTH];

  // Only the low bits of the bus id select an entry
  logic [STREAM_ID_WIDTH-1:0] ctx_idx;

  // Restore register, valid bit is control, state is payload
  logic       restore_vld_q;
  dfa_state_e restore_state_q;

  assign ctx_idx = ctl_in.stream_id[STREAM_ID_WIDTH-1:0];

  // Restore strobe lasts one cycle per load
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      restore_vld_q <= 1'b0;
    end
    else
    begin
      restore_vld_q <= ctl_in.load_state;
    end
  end

  // Fresh streams start at idle, known streams pick up where they left off
  always_ff @(posedge clk)
  begin
    if (ctl_in.load_state)
    begin
      if (ctl_in.new_stream)
      begin
        restore_state_q <= S_IDLE;
      end
      else
      begin
        restore_state_q <= ctx_mem[ctx_idx];
      end
    end
  end

  // Save final state of an enabled packet so a match can span packets
  always_ff @(posedge clk)
  begin
    if (ctl_in.eop && ctl_in.enable)
    begin
      ctx_mem[ctx_idx] <= dfa_out.state;
    end
  end

  assign restore.restore_vld   = restore_vld_q;
  assign restore.restore_state = restore_state_q;

  // A packet cannot start and end on the same strobe
  a_no_load_at_eop : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ctl_in.load_state && ctl_in.eop)
  );

endmodule

`default_nettype wire

//--- src/login_dfa.sv
`default_nettype none

module login_dfa (
  input  logic                         clk,
  input  logic                         rst_n,
  input  imap_match_pkg::char_beat_t   beat_in,
  input  imap_match_pkg::dfa_restore_t restore,
  output imap_match_pkg::dfa_result_t  dfa_out
);

  import imap_match_pkg::*;

  // Input registers
  logic       char_vld_r;
  logic [7:0] char_val_r;
  logic       restore_vld_r;
  dfa_state_e restore_state_r;

  // Output registers
  dfa_state_e state_q;
  logic       accept_q;

  // Next-state logic
  dfa_state_e base_state;
  dfa_state_e next_state;
  logic [7:0] char_up;
  logic       next_accept;

  // Map lower case letters onto upper case
  function automatic logic [7:0] fold_case(input logic [7:0] c);
    if (c >= "a" && c <= "z")
      return c - 8'h20;
    return c;
  endfunction

  // Letter that moves each prefix state one step forward
  function automatic logic [7:0] expected_char(input dfa_state_e s);
    case (s)
      S_IDLE:  return "L";
      S_L:     return "O";
      S_LO:    return "G";
      S_LOG:   return "I";
      S_LOGI:  return "N";
      default: return "L";
    endcase
  endfunction

  // Valid bits cleared by reset, payload just follows the input
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r    <= 1'b0;
      restore_vld_r <= 1'b0;
    end
    else
    begin
      char_vld_r    <= beat_in.char_vld;
      restore_vld_r <= restore.restore_vld;
    end
  end

  always_ff @(posedge clk)
  begin
    char_val_r      <= beat_in.char_val;
    restore_state_r <= restore.restore_state;
  end

  always_comb
  begin
    char_up = fold_case(char_val_r);
    // After a full match the next letter starts over
    base_state  = (state_q == S_LOGIN) ? S_IDLE : state_q;
    next_state  = state_q;
    next_accept = 1'b0;
    if (restore_vld_r)
    begin
      // Restore wins, any character this cycle is dropped
      next_state = restore_state_r;
    end
    else if (char_vld_r)
    begin
      if (char_up == expected_char(base_state))
        next_state = dfa_state_e'(base_state + 3'd1);
      else if (char_up == "L")
        next_state = S_L;
      else
        next_state = S_IDLE;
      next_accept = (next_state == S_LOGIN);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= S_IDLE;
      accept_q <= 1'b0;
    end
    else
    begin
      state_q  <= next_state;
      accept_q <= next_accept;
    end
  end

  assign dfa_out.accept = accept_q;
  assign dfa_out.state  = state_q;

  // Restored and stepped states both stay inside the LOGIN encodings
  a_state_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q inside {S_IDLE, S_L, S_LO, S_LOG, S_LOGI, S_LOGIN}
  );

endmodule

`default_nettype wire

//--- src/match_counter.sv
`default_nettype none

module match_counter #(
  parameter int COUNT_WIDTH = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  imap_match_pkg::stream_ctl_t ctl_in,
  input  imap_match_pkg::dfa_result_t dfa_out,
  output logic [COUNT_WIDTH-1:0]      count,
  output logic                        fired
);

  import imap_match_pkg::*;

  // Sticky per-packet match flag
  logic fired_q;

  // Running count of enabled packets that matched
  logic [COUNT_WIDTH-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired_q <= 1'b0;
      count_q <= '0;
    end
    else
    begin
      // Start of packet drops the old flag
      if (ctl_in.load_state)
        fired_q <= 1'b0;
      if (ctl_in.eop)
      begin
        if (ctl_in.enable)
          // Wraps at the counter width
          count_q <= count_q + COUNT_WIDTH'(fired_q);
        else
          fired_q <= 1'b0;
      end
      // Accept wins over any clear in the same cycle
      if (dfa_out.accept)
        fired_q <= 1'b1;
    end
  end

  assign count = count_q;
  assign fired = fired_q;

  // Count only moves on the edge after an enabled end of packet
  a_count_at_eop : assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(count_q) |-> $past(ctl_in.eop && ctl_in.enable)
  );

endmodule

`default_nettype wire

//--- src/imap_matcher_top.sv
`default_nettype none

module imap_matcher_top #(
  parameter int STREAM_ID_WIDTH = 6,
  parameter int COUNT_WIDTH     = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  imap_match_pkg::char_beat_t  beat_in,
  input  imap_match_pkg::stream_ctl_t ctl_in,
  output logic [COUNT_WIDTH-1:0]      count,
  output logic                        fired
);

  import imap_match_pkg::*;

  // Restore path from context memory into the automaton
  dfa_restore_t restore;

  // Registered automaton outputs, shared by save and result
  dfa_result_t dfa_out;

  // Decode, per-stream state restore and save
  stream_context #(
    .STREAM_ID_WIDTH (STREAM_ID_WIDTH)
  ) u_stream_context (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctl_in  (ctl_in),
    .dfa_out (dfa_out),
    .restore (restore)
  );

  // Execute, the LOGIN automaton
  login_dfa u_login_dfa (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat_in (beat_in),
    .restore (restore),
    .dfa_out (dfa_out)
  );

  // Result, match flag and count
  match_counter #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_match_counter (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctl_in  (ctl_in),
    .dfa_out (dfa_out),
    .count   (count),
    .fired   (fired)
  );

endmodule

`default_nettype wire

//--- testbench/match_checker.sv
`default_nettype none

module match_checker #(
  parameter int COUNT_WIDTH = 16
) (
  input  logic                   clk,
  input  logic                   check_stb,
  input  logic [127:0]           check_name,
  input  logic [COUNT_WIDTH-1:0] exp_count,
  input  logic                   exp_fired,
  input  logic [COUNT_WIDTH-1:0] count,
  input  logic                   fired,
  input  logic                   report_req,
  output int                     checks_done,
  output int                     checks_failed
);

  timeunit 1ns;
  timeprecision 1ps;

  int done_q   = 0;
  int failed_q = 0;

  // Request was raised on the previous edge
  // DUT outputs seen here are the values held during that cycle
  always @(posedge clk)
  begin
    if (check_stb)
    begin
      done_q <= done_q + 1;
      // Four-state compare so an unknown output also fails
      if (count !== exp_count || fired !== exp_fired)
      begin
        failed_q <= failed_q + 1;
        $display("FAIL %0t %0s: expected count %0d fired %0b, got count %0d fired %0b",
                 $time, check_name, exp_count, exp_fired, count, fired);
      end
      else
      begin
        $display("ok   %0t %0s: count %0d fired %0b", $time, check_name, count, fired);
      end
    end
    if (report_req)
    begin
      $display("Checks: %0d run, %0d passed, %0d failed",
               done_q, done_q - failed_q, failed_q);
    end
  end

  assign checks_done   = done_q;
  assign checks_failed = failed_q;

endmodule

`default_nettype wire

//--- testbench/tb_imap_matcher.sv
`default_nettype none

module tb_imap_matcher;

  timeunit 1ns;
  timeprecision 1ps;

  import imap_match_pkg::*;

  localparam int    STREAM_ID_WIDTH = 6;
  localparam int    COUNT_WIDTH     = 16;
  localparam int    RESET_CYCLES    = 4;
  localparam int    MARGIN_CYCLES   = 100;
  localparam string TRACE_PATH      = "testbench/imap_trace.txt";

  // One parsed trace line, text holds the characters or the test name
  typedef struct packed {
    logic [7:0]   op;
    logic [31:0]  arg0;
    logic [31:0]  arg1;
    logic [31:0]  arg2;
    logic [127:0] text;
  } trace_cmd_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  char_beat_t             beat_in;
  stream_ctl_t            ctl_in;
  logic [COUNT_WIDTH-1:0] count;
  logic                   fired;

  // Check request and summary strobe towards the checker
  logic                   check_stb;
  logic [127:0]           check_name;
  logic [COUNT_WIDTH-1:0] exp_count;
  logic                   exp_fired;
  logic                   report_req;
  int                     checks_done;
  int                     checks_failed;

  trace_cmd_t cmds[$];
  int         trace_errors = 0;
  int         cycle_limit  = 0;
  int         cycle_cnt    = 0;

  always #5 clk = ~clk;

  imap_matcher_top #(
    .STREAM_ID_WIDTH (STREAM_ID_WIDTH),
    .COUNT_WIDTH     (COUNT_WIDTH)
  ) dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat_in (beat_in),
    .ctl_in  (ctl_in),
    .count   (count),
    .fired   (fired)
  );

  match_checker #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_checker (
    .clk           (clk),
    .check_stb     (check_stb),
    .check_name    (check_name),
    .exp_count     (exp_count),
    .exp_fired     (exp_fired),
    .count         (count),
    .fired         (fired),
    .report_req    (report_req),
    .checks_done   (checks_done),
    .checks_failed (checks_failed)
  );

  // Run limit comes from the trace length, stays off until the trace is read
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: run still busy after %0d cycles", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Characters sit right-aligned, unused upper bytes are zero
  function automatic int word_length(input logic [127:0] word);
    int n;
    int i;
    n = 0;
    for (i = 0; i < 16; i++)
      if (word[i*8 +: 8] != 8'h00)
        n++;
    return n;
  endfunction

  // Parse the whole trace up front and tally the cycles it needs
  task automatic read_trace(input int fd, output int cycles);
    logic [7:0]    op;
    logic [127:0]  text;
    logic [1023:0] line;
    int            a0;
    int            a1;
    int            a2;
    int            got;
    logic          ok;
    logic          done;
    trace_cmd_t    cmd;
    cycles = 0;
    done   = 1'b0;
    while (!done)
    begin
      got = $fscanf(fd, "%s", op);
      if (got != 1)
        done = 1'b1;
      else if (op == "#")
        got = $fgets(line, fd);
      else
      begin
        a0   = 0;
        a1   = 0;
        a2   = 0;
        text = '0;
        case (op)
          "L":     ok = ($fscanf(fd, "%d %d %d", a0, a1, a2) == 3);
          "C":     ok = ($fscanf(fd, "%s", text) == 1);
          "W":     ok = ($fscanf(fd, "%d", a0) == 1);
          "E":     ok = 1'b1;
          "X":     ok = ($fscanf(fd, "%s %d %d", text, a1, a2) == 3);
          default: ok = 1'b0;
        endcase
        if (!ok)
        begin
          trace_errors++;
          $display("Trace line starting with '%c' could not be read", op);
        end
        else
        begin
          cmd.op   = op;
          cmd.arg0 = a0;
          cmd.arg1 = a1;
          cmd.arg2 = a2;
          cmd.text = text;
          cmds.push_back(cmd);
          // Load carries its own quiet cycle
          case (op)
            "L":     cycles += 2;
            "C":     cycles += word_length(text);
            "W":     cycles += a0;
            default: cycles += 1;
          endcase
        end
      end
    end
  endtask

  // Pulses fall every cycle unless a command raises them again
  task automatic drop_strobes();
    ctl_in.load_state <= 1'b0;
    ctl_in.eop        <= 1'b0;
    beat_in.char_vld  <= 1'b0;
    check_stb         <= 1'b0;
  endtask

  // Stream id and enable are levels held until the next load
  task automatic load_stream(input int id, input int fresh, input int en);
    @(posedge clk);
    drop_strobes();
    ctl_in.load_state <= 1'b1;
    ctl_in.new_stream <= fresh[0];
    ctl_in.enable     <= en[0];
    ctl_in.stream_id  <= id[STREAM_ID_WIDTH_MAX-1:0];
    // Quiet cycle so the restore reaches the automaton before the first character
    @(posedge clk);
    drop_strobes();
  endtask

  // Leftmost character goes first
  task automatic push_chars(input logic [127:0] word);
    int i;
    for (i = 15; i >= 0; i--)
      if (word[i*8 +: 8] != 8'h00)
      begin
        @(posedge clk);
        drop_strobes();
        beat_in.char_vld <= 1'b1;
        beat_in.char_val <= word[i*8 +: 8];
      end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      drop_strobes();
    end
  endtask

  task automatic end_packet();
    @(posedge clk);
    drop_strobes();
    ctl_in.eop <= 1'b1;
  endtask

  task automatic request_check(input logic [127:0] name, input int cnt, input int f);
    @(posedge clk);
    drop_strobes();
    check_stb  <= 1'b1;
    check_name <= name;
    exp_count  <= cnt[COUNT_WIDTH-1:0];
    exp_fired  <= f[0];
  endtask

  initial
  begin
    int fd;
    int trace_cycles;
    rst_n      <= 1'b0;
    beat_in    <= '0;
    ctl_in     <= '0;
    check_stb  <= 1'b0;
    check_name <= '0;
    exp_count  <= '0;
    exp_fired  <= 1'b0;
    report_req <= 1'b0;
    fd = $fopen(TRACE_PATH, "r");
    if (fd == 0)
    begin
      $display("Cannot open trace file %0s, nothing was run", TRACE_PATH);
      $display(">>> FAIL");
      $finish;
    end
    else
    begin
      read_trace(fd, trace_cycles);
      $fclose(fd);
      // Reset, summary tail and a fixed margin on top of the trace
      cycle_limit = trace_cycles + RESET_CYCLES + 4 + MARGIN_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      foreach (cmds[n])
      begin
        case (cmds[n].op)
          "L":     load_stream(cmds[n].arg0, cmds[n].arg1, cmds[n].arg2);
          "C":     push_chars(cmds[n].text);
          "W":     idle_cycles(cmds[n].arg0);
          "E":     end_packet();
          default: request_check(cmds[n].text, cmds[n].arg1, cmds[n].arg2);
        endcase
      end
      idle_cycles(1);
      @(posedge clk);
      report_req <= 1'b1;
      @(posedge clk);
      report_req <= 1'b0;
      // Summary line is out, verdict follows on the next edge
      @(posedge clk);
      if (checks_failed == 0 && trace_errors == 0 && checks_done > 0)
        $display(">>> PASS");
      else
        $display(">>> FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/imap_trace.txt
# L stream new enable | C characters, one per cycle | W idle cycles | E end of packet
# X test_name expected_count expected_fired, as seen on that cycle
L 1 1 1
C login
W 2
X new_stream_fired 0 1
E
X new_stream_count 1 1
L 2 1 1
X load_clears_flag 1 0
C LLOGIN
W 2
E
X restart_match 2 1
L 3 1 1
C LoGiN
W 2
E
X mixed_case 3 1
L 4 1 1
C LOGXN
W 2
E
X broken_word 3 0
L 5 1 1
C LOG
W 2
E
X save_partial 3 0
L 9 1 1
C LOGI
W 2
E
X other_stream 3 0
L 5 0 1
C IN
W 2
X resumed_fired 3 1
E
X resumed_count 4 1
L 6 1 0
C LOGIN
W 2
X disabled_fired 4 1
E
X disabled_count 4 0
L 5 1 1
C LOG
W 2
E
X save_again 4 0
L 5 1 1
C IN
W 2
E
X new_stream_wins 4 0

//--- flist.f
src/imap_match_pkg.sv
src/stream_context.sv
src/login_dfa.sv
src/match_counter.sv
src/imap_matcher_top.sv
testbench/match_checker.sv
testbench/tb_imap_matcher.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run from the project root, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_imap_matcher -Mdir obj_dir -o sim_imap -f flist.f || exit 1
sim_out=$(./obj_dir/sim_imap)
echo "$sim_out"
echo "$sim_out" | grep -qx '>>> PASS' && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
